/* build.f */
link_pkg.sv
credit_counter.sv
vc_sender.sv
link_arbiter.sv
rx_vc_fifo.sv
credit_link_top.sv
tb_credit_link.sv

/* run.sh */
#!/bin/sh
# Build the credit link testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_credit_link -f build.f \
  && ./obj_dir/Vtb_credit_link | tee /dev/stderr | grep "SIMULATION PASSED" > /dev/null \
  && echo "run.sh: simulation ok" \
  || { echo "run.sh: build or simulation failed"; exit 1; }

/* tb_credit_link.sv */
//--------------------
// Credit link testbench
//--------------------

module tb_credit_link;

  localparam int fifo_depth = 4;
  localparam int cnt_width  = $clog2(fifo_depth + 1);
  localparam int dw         = link_pkg::data_width;
  // Phase lengths in cycles
  localparam int mix_cycles   = 800;
  localparam int hold_cycles  = 300;
  localparam int stall_cycles = 100;
  localparam int drain_limit  = 200;
  localparam int total_cycles = 10 + mix_cycles + 4 * hold_cycles + stall_cycles + drain_limit;

  logic                 clk;
  logic                 rst_n;
  logic                 in_valid  [2];
  logic [dw-1:0]        in_data   [2];
  logic                 in_ready  [2];
  logic [cnt_width-1:0] withhold  [2];
  logic                 out_valid [2];
  logic [dw-1:0]        out_data  [2];
  logic                 out_ready [2];
  logic                 link_valid;
  link_pkg::flit_t      link_flit;

  // Reference queues, accepted but not yet popped
  logic [dw-1:0] model_q [2][$];
  logic [15:0]   lfsr_q = 16'd98;
  int err_data   = 0;
  int err_bound  = 0;
  int err_hold   = 0;
  int err_fair   = 0;
  int err_resume = 0;
  int err_drain  = 0;
  int err_ready  = 0;
  int link_cnt [2] = '{0, 0};

  // Sender state as the model sees it, one cycle behind the link
  logic                 hold_full   [2] = '{1'b0, 1'b0};
  int                   credits     [2] = '{fifo_depth, fifo_depth};
  logic                 accept_prev [2] = '{1'b0, 1'b0};
  logic                 pop_prev    [2] = '{1'b0, 1'b0};
  logic                 ready_prev  [2] = '{1'b1, 1'b1};
  logic [cnt_width-1:0] wh_prev     [2] = '{'0, '0};
  logic                 both_prev = 1'b0;
  logic                 link_prev = 1'b0;
  link_pkg::vc_t        vc_prev   = 1'b0;

  credit_link_top #(
    .fifo_depth (fifo_depth)
  ) uut (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .in_data    (in_data),
    .in_ready   (in_ready),
    .withhold   (withhold),
    .out_valid  (out_valid),
    .out_data   (out_data),
    .out_ready  (out_ready),
    .link_valid (link_valid),
    .link_flit  (link_flit)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  //--------------------
  // Stimulus helpers
  //--------------------

  // Galois LFSR, one step per bit taken
  function automatic logic [15:0] take_bits(input int n);
    logic [15:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      val    = {val[14:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 16'hB400) : (lfsr_q >> 1);
    end
    return val;
  endfunction

  // Negative withhold means a random 0 to 3 each cycle
  task automatic drive_cycle(input int wh0, input int wh1, input bit stall);
    int wh;
    @(posedge clk);
    #2;
    for (int v = 0; v < 2; v++) begin
      wh           = (v == 0) ? wh0 : wh1;
      in_valid[v]  = (take_bits(2) != 16'd0);
      in_data[v]   = take_bits(16);
      out_ready[v] = stall ? 1'b0 : (take_bits(2) != 16'd0);
      withhold[v]  = (wh < 0) ? cnt_width'(take_bits(2)) : cnt_width'(wh);
    end
  endtask

  task automatic run_phase(input int cycles, input int wh0, input int wh1, input bit stall);
    repeat (cycles) drive_cycle(wh0, wh1, stall);
  endtask

  //--------------------
  // Monitor
  //--------------------

  always @(negedge clk) begin : monitor
    logic          req_m [2];
    logic          grant_m;
    logic          both_now;
    logic [dw-1:0] expected;
    if (rst_n) begin
      // Link now shows the grant of the previous cycle
      for (int v = 0; v < 2; v++) begin
        req_m[v] = hold_full[v] && (credits[v] > int'(wh_prev[v]));
        if (link_valid && (link_flit.vc == link_pkg::vc_t'(v))) begin
          link_cnt[v]++;
          assert (wh_prev[v] != cnt_width'(fifo_depth)) else begin
            err_hold++;
            $display("VC %0d sent a flit while all of its credits were withheld", v);
          end
        end
      end
      both_now = req_m[0] && req_m[1];
      if (both_now && both_prev && link_valid && link_prev) begin
        assert (link_flit.vc != vc_prev) else begin
          err_fair++;
          $display("FAIL link_flit.vc expected %h got %h", !vc_prev, link_flit.vc);
        end
      end
      both_prev = both_now;
      link_prev = link_valid;
      vc_prev   = link_flit.vc;
      for (int v = 0; v < 2; v++) begin
        // Advance the model sender by one cycle
        grant_m      = link_valid && (link_flit.vc == link_pkg::vc_t'(v));
        // Ready of the cycle before, its grant now known
        assert (ready_prev[v] == (!hold_full[v] || grant_m)) else begin
          err_ready++;
          $display("FAIL in_ready[%0d] expected %h got %h",
                   v, !hold_full[v] || grant_m, ready_prev[v]);
        end
        credits[v]   = credits[v] + int'(pop_prev[v]) - int'(grant_m);
        hold_full[v] = accept_prev[v] ? 1'b1 : (grant_m ? 1'b0 : hold_full[v]);
        // Handshakes that complete at the coming edge
        accept_prev[v] = in_valid[v] && in_ready[v];
        pop_prev[v]    = out_valid[v] && out_ready[v];
        ready_prev[v]  = in_ready[v];
        wh_prev[v]     = withhold[v];
        if (accept_prev[v]) begin
          model_q[v].push_back(in_data[v]);
        end
        if (pop_prev[v]) begin
          assert (model_q[v].size() != 0) else begin
            err_data++;
            $display("VC %0d delivered a flit that was never sent", v);
          end
          if (model_q[v].size() != 0) begin
            expected = model_q[v].pop_front();
            assert (out_data[v] == expected) else begin
              err_data++;
              $display("FAIL out_data[%0d] expected %h got %h", v, expected, out_data[v]);
            end
          end
        end
        // FIFO plus holding register
        assert (model_q[v].size() <= fifo_depth + 1) else begin
          err_bound++;
          $display("VC %0d has %0d flits in flight, more than credits allow",
                   v, model_q[v].size());
        end
      end
    end
  end

  //--------------------
  // Test sequence
  //--------------------

  initial begin
    int   base;
    int   total;
    logic drained;
    rst_n = 1'b0;
    for (int v = 0; v < 2; v++) begin
      in_valid[v]  = 1'b0;
      in_data[v]   = '0;
      out_ready[v] = 1'b0;
      withhold[v]  = '0;
    end
    repeat (10) @(posedge clk);
    #2;
    rst_n = 1'b1;
    // Random traffic and random withhold
    run_phase(mix_cycles, -1, -1, 1'b0);
    // Each VC fully withheld, then released
    for (int v = 0; v < 2; v++) begin
      run_phase(hold_cycles, (v == 0) ? fifo_depth : 0, (v == 1) ? fifo_depth : 0, 1'b0);
      base = link_cnt[v];
      run_phase(hold_cycles, 0, 0, 1'b0);
      assert (link_cnt[v] > base) else begin
        err_resume++;
        $display("VC %0d traffic did not resume after withhold was cleared", v);
      end
    end
    // Consumer stalled, FIFOs fill and credits run out
    run_phase(stall_cycles, 0, 0, 1'b1);
    @(posedge clk);
    #2;
    for (int v = 0; v < 2; v++) begin
      in_valid[v]  = 1'b0;
      out_ready[v] = 1'b1;
      withhold[v]  = '0;
    end
    drained = 1'b0;
    for (int c = 0; c < drain_limit && !drained; c++) begin
      @(posedge clk);
      drained = (model_q[0].size() == 0) && (model_q[1].size() == 0);
    end
    assert (drained) else begin
      err_drain++;
      $display("Link did not drain within %0d cycles", drain_limit);
    end
    total = err_data + err_bound + err_hold + err_fair + err_resume + err_drain + err_ready;
    $display({"Errors: data %0d, bound %0d, withhold %0d, fairness %0d, ",
              "resume %0d, drain %0d, ready %0d"},
             err_data, err_bound, err_hold, err_fair, err_resume, err_drain, err_ready);
    if (total == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(total_cycles * 20 + 1000);
    $display("Watchdog expired before the test sequence finished");
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

/* credit_link_top.sv */
//--------------------
// Credit link top
//--------------------

module credit_link_top #(
  // Receive FIFO depth per VC
  parameter int fifo_depth = 4,
  localparam int cnt_width = $clog2(fifo_depth + 1)
) (
  input  logic                            clk,
  input  logic                            rst_n,
  // Client side, one lane per VC
  input  logic                            in_valid  [2],
  input  logic [link_pkg::data_width-1:0] in_data   [2],
  output logic                            in_ready  [2],
  input  logic [cnt_width-1:0]            withhold  [2],
  // Consumer side
  output logic                            out_valid [2],
  output logic [link_pkg::data_width-1:0] out_data  [2],
  input  logic                            out_ready [2],
  // Link monitor
  output logic                            link_valid,
  output link_pkg::flit_t                 link_flit
);

  logic                  req        [2];
  logic                  grant      [2];
  link_pkg::flit_t       flit       [2];
  logic                  push       [2];
  logic                  credit_in  [2];
  link_pkg::credit_ret_t credit_ret [2];

  //--------------------
  // Per-VC lanes
  //--------------------

  for (genvar v = 0; v < 2; v++) begin : g_vc
    vc_sender #(
      .fifo_depth (fifo_depth),
      .vc_id      (link_pkg::vc_t'(v))
    ) u_sender (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_valid  (in_valid[v]),
      .in_data   (in_data[v]),
      .in_ready  (in_ready[v]),
      .withhold  (withhold[v]),
      .credit_in (credit_in[v]),
      .req       (req[v]),
      .flit      (flit[v]),
      .grant     (grant[v])
    );

    // Link demux by VC tag
    assign push[v] = link_valid && (link_flit.vc == link_pkg::vc_t'(v));

    // Return path steered by the credit VC tag
    assign credit_in[v] =
      (credit_ret[0].valid && (credit_ret[0].vc == link_pkg::vc_t'(v))) ||
      (credit_ret[1].valid && (credit_ret[1].vc == link_pkg::vc_t'(v)));

    rx_vc_fifo #(
      .fifo_depth (fifo_depth)
    ) u_rx (
      .clk        (clk),
      .rst_n      (rst_n),
      .push       (push[v]),
      .push_data  (link_flit),
      .out_valid  (out_valid[v]),
      .out_data   (out_data[v]),
      .out_ready  (out_ready[v]),
      .credit_ret (credit_ret[v])
    );
  end

  // Shared link
  link_arbiter u_arb (
    .clk        (clk),
    .rst_n      (rst_n),
    .req0       (req[0]),
    .flit0      (flit[0]),
    .grant0     (grant[0]),
    .req1       (req[1]),
    .flit1      (flit[1]),
    .grant1     (grant[1]),
    .link_valid (link_valid),
    .link_flit  (link_flit)
  );

endmodule

/* rx_vc_fifo.sv */
//--------------------
// Receive VC FIFO
//--------------------

module rx_vc_fifo #(
  // Entries, matches the sender credit pool
  parameter int fifo_depth = 4
) (
  input  logic                            clk,
  input  logic                            rst_n,
  // Link side, no back-pressure
  input  logic                            push,
  input  link_pkg::flit_t                 push_data,
  // Consumer handshake
  output logic                            out_valid,
  output logic [link_pkg::data_width-1:0] out_data,
  input  logic                            out_ready,
  // One credit per pop, a cycle later
  output link_pkg::credit_ret_t           credit_ret
);

  localparam int ptr_width = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
  localparam int cnt_width = $clog2(fifo_depth + 1);

  link_pkg::flit_t      mem [fifo_depth];
  logic [ptr_width-1:0] wr_ptr;
  logic [ptr_width-1:0] rd_ptr;
  logic [cnt_width-1:0] count;
  logic                 pop;

  //--------------------
  // Storage
  //--------------------

  assign out_valid = (count != '0);
  assign out_data  = mem[rd_ptr].data;
  assign pop       = out_valid && out_ready;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  // Pointers wrap at fifo_depth, any depth works
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == ptr_width'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == ptr_width'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  //--------------------
  // Credit return
  //--------------------

  // VC tag taken from the popped flit
  always_ff @(posedge clk) begin
    credit_ret.vc <= mem[rd_ptr].vc;
    if (!rst_n) begin
      credit_ret.valid <= 1'b0;
    end else begin
      credit_ret.valid <= pop;
    end
  end

  // Sender credits keep the FIFO from overrunning
  a_no_push_full: assert property (
    @(posedge clk) disable iff (!rst_n)
    push |-> (count != cnt_width'(fifo_depth))
  ) else $error("rx_vc_fifo: push into full FIFO");

  // Stalled head stays put for the consumer
  a_stall_stable: assert property (
    @(posedge clk) disable iff (!rst_n)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_data))
  ) else $error("rx_vc_fifo: head changed while stalled");

endmodule

/* link_arbiter.sv */
//--------------------
// Link arbiter
//--------------------

module link_arbiter (
  input  logic            clk,
  input  logic            rst_n,
  // VC 0 sender
  input  logic            req0,
  input  link_pkg::flit_t flit0,
  output logic            grant0,
  // VC 1 sender
  input  logic            req1,
  input  link_pkg::flit_t flit1,
  output logic            grant1,
  // Registered link stage
  output logic            link_valid,
  output link_pkg::flit_t link_flit
);

  link_pkg::arb_last_e last_q;
  logic                any_grant;

  //--------------------
  // Round robin
  //--------------------

  always_comb begin
    grant0 = 1'b0;
    grant1 = 1'b0;
    if (req0 && req1) begin
      // Both want the link, the other VC goes first
      if (last_q == link_pkg::last_vc0) begin
        grant1 = 1'b1;
      end else begin
        grant0 = 1'b1;
      end
    end else begin
      grant0 = req0;
      grant1 = req1;
    end
  end

  assign any_grant = grant0 || grant1;

  // Pointer follows the winner, VC 0 first out of reset
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      last_q <= link_pkg::last_vc1;
    end else if (grant0) begin
      last_q <= link_pkg::last_vc0;
    end else if (grant1) begin
      last_q <= link_pkg::last_vc1;
    end
  end

  //--------------------
  // Link register
  //--------------------

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      link_valid <= 1'b0;
    end else begin
      link_valid <= any_grant;
    end
  end

  // Flit payload, one cycle after the grant
  always_ff @(posedge clk) begin
    if (any_grant) begin
      link_flit <= grant1 ? flit1 : flit0;
    end
  end

  a_one_hot_grant: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(grant0 && grant1)
  ) else $error("link_arbiter: both VCs granted");

endmodule

/* vc_sender.sv */
//--------------------
// Per-VC sender
//--------------------

module vc_sender #(
  // Receive FIFO depth, sets the credit pool
  parameter int fifo_depth = 4,
  // VC number stamped on every flit
  parameter link_pkg::vc_t vc_id = 1'b0,
  localparam int cnt_width = $clog2(fifo_depth + 1)
) (
  input  logic                            clk,
  input  logic                            rst_n,
  // Client handshake
  input  logic                            in_valid,
  input  logic [link_pkg::data_width-1:0] in_data,
  output logic                            in_ready,
  // Credits held back by the system
  input  logic [cnt_width-1:0]            withhold,
  // One credit back from the receiver
  input  logic                            credit_in,
  // Arbiter side
  output logic                            req,
  output link_pkg::flit_t                 flit,
  input  logic                            grant
);

  logic                            full_q;
  logic [link_pkg::data_width-1:0] data_q;
  logic [cnt_width-1:0]            credit_avail;

  //--------------------
  // Holding register
  //--------------------

  // Free slot, or the slot empties this cycle
  assign in_ready = !full_q || grant;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      full_q <= 1'b0;
    end else if (in_valid && in_ready) begin
      full_q <= 1'b1;
    end else if (grant) begin
      full_q <= 1'b0;
    end
  end

  // Payload only, loaded on accept
  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      data_q <= in_data;
    end
  end

  assign flit.vc   = vc_id;
  assign flit.data = data_q;

  // Ask for the link with a flit held and credit to spend
  assign req = full_q && (credit_avail != '0);

  // Grant spends one credit, returns from the FIFO add one
  credit_counter #(
    .max_credits  (fifo_depth),
    .init_credits (fifo_depth)
  ) u_credits (
    .clk       (clk),
    .rst_n     (rst_n),
    .incr      (credit_in),
    .decr      (grant),
    .withhold  (withhold),
    .value     (),
    .available (credit_avail)
  );

  // Arbiter grants only a live request
  a_grant_needs_req: assert property (
    @(posedge clk) disable iff (!rst_n)
    grant |-> req
  ) else $error("vc_sender: grant without request");

endmodule

/* credit_counter.sv */
//--------------------
// Credit counter
//--------------------

module credit_counter #(
  // Largest credit count the pool may hold
  parameter int max_credits = 4,
  // Count loaded on reset
  parameter int init_credits = 4,
  localparam int cnt_width = $clog2(max_credits + 1)
) (
  input  logic                 clk,
  input  logic                 rst_n,
  // One credit returned by the receiver
  input  logic                 incr,
  // One credit spent on a sent flit
  input  logic                 decr,
  // Credits kept out of circulation
  input  logic [cnt_width-1:0] withhold,
  // Stored count, before increment and withhold
  output logic [cnt_width-1:0] value,
  // Spendable credit this cycle
  output logic [cnt_width-1:0] available
);

  // One spare bit so overflow and underflow stay visible
  localparam int ext_width = cnt_width + 1;

  logic [ext_width-1:0] value_plus_incr;
  logic [ext_width-1:0] value_next;
  logic [ext_width-1:0] withhold_ext;

  //--------------------
  // Next count
  //--------------------

  // Return and spend can land in the same cycle
  assign value_plus_incr = {1'b0, value} + ext_width'(incr);
  assign value_next      = value_plus_incr - ext_width'(decr);
  assign withhold_ext    = {1'b0, withhold};

  // Decrement left out here, it depends on available through the grant
  always_comb begin
    if (value_plus_incr > withhold_ext) begin
      available = cnt_width'(value_plus_incr - withhold_ext);
    end else begin
      // Floor at zero when withhold exceeds the pool
      available = '0;
    end
  end

  // Count register, only moves on a return or a spend
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      value <= cnt_width'(init_credits);
    end else if (incr || decr) begin
      value <= value_next[cnt_width-1:0];
    end
  end

  //--------------------
  // Checks
  //--------------------

  // Receiver returns at most what was spent
  // Also flags underflow, which wraps above max
  a_no_overflow: assert property (
    @(posedge clk) disable iff (!rst_n)
    value_next <= ext_width'(max_credits)
  ) else $error("credit_counter: count past max_credits");

  // Sender spends only when credit is there
  a_decr_with_credit: assert property (
    @(posedge clk) disable iff (!rst_n)
    decr |-> (available != '0)
  ) else $error("credit_counter: decrement with no available credit");

  // Withhold never larger than the pool
  a_withhold_range: assert property (
    @(posedge clk) disable iff (!rst_n)
    withhold <= cnt_width'(max_credits)
  ) else $error("credit_counter: withhold out of range");

endmodule

/* link_pkg.sv */
//--------------------
// Credit link shared types
//--------------------

package link_pkg;

  //--------------------
  // Widths
  //--------------------

  // Flit payload width in bits
  localparam int data_width = 16;

  //--------------------
  // Link types
  //--------------------

  // Virtual channel index, two VCs
  typedef logic vc_t;

  // One flit on the link, VC tag above the payload
  typedef struct packed {
    vc_t                   vc;
    logic [data_width-1:0] data;
  } flit_t;

  // One returned credit on the receiver to sender path
  typedef struct packed {
    logic valid;
    vc_t  vc;
  } credit_ret_t;

  //--------------------
  // Arbiter state
  //--------------------

  // Round-robin pointer, the VC that won the last grant
  typedef enum logic {
    last_vc0 = 1'b0,
    last_vc1 = 1'b1
  } arb_last_e;

endpackage
